// ==== list.f ====
+incdir+source
source/udp_pkg.sv
source/udp_hdr_if.sv
source/eth_csr.sv
source/byte_fifo.sv
source/udp_tx_framer.sv
source/udp_rx_parser.sv
source/udp_bridge_top.sv
bench/udp_bridge_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module udp_bridge_tb -o udp_bridge_sim
out=$(./obj_dir/udp_bridge_sim 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1

// ==== bench/udp_bridge_tb.sv ====
// Randomized testbench for the UDP bridge, compiled from the file list and run by the script
`timescale 1ns/1ns
`include "udp_params.svh"

module udp_bridge_tb
  import udp_pkg::*;
();

  localparam int N_PKTS = 8;
  localparam int MAX_LEN = 40;
  // About 4000 cycles of traffic, five times over
  localparam int CYCLE_LIMIT = 20000;

  logic                   clk_axi;
  logic                   rst_axi;
  logic                   csr_wr;
  logic                   csr_rd;
  logic [`CSR_ADDR_W-1:0] csr_addr;
  logic [`CSR_DATA_W-1:0] csr_wdata;
  logic [`CSR_DATA_W-1:0] csr_rdata;
  logic                   out_wr;
  logic [`UDP_DATA_W-1:0] out_data;
  logic                   out_full;
  logic                   in_rd;
  logic [`UDP_DATA_W-1:0] in_data;
  logic                   in_last;
  logic                   in_empty;
  logic                   tx_valid;
  logic [`UDP_DATA_W-1:0] tx_data;
  logic                   tx_last;
  logic                   tx_credit = 1'b0;
  logic                   rx_valid;
  logic [`UDP_DATA_W-1:0] rx_data;
  logic                   rx_last;
  logic                   rx_credit;
  logic                   pkt_sent;
  logic                   pkt_recv;

  int         seed = 32'hc144;
  int         value_errors = 0;
  int         flow_errors = 0;
  int         cycle_count = 0;
  int         beats_sent = 0;
  int         credits_returned = 0;
  int         credit_wait = 0;
  int         rx_credits = `UDP_FIFO_DEPTH;
  int         rx_credit_pulses = 0;
  int         rx_bytes_total = 0;
  int         out_level = 0;
  int         in_level = 0;
  int         tx_idx = 0;
  int         rx_idx = 0;
  logic       sent_due = 1'b0;
  int         delay_tab [64];
  logic [7:0] exp_tx [$];
  logic       exp_tx_last [$];
  logic [7:0] rx_frame [$];
  logic [7:0] rx_payload [$];

  udp_bridge_top i_dut (
    .i_clk_axi   (clk_axi),
    .i_rst_axi   (rst_axi),
    .i_csr_wr    (csr_wr),
    .i_csr_rd    (csr_rd),
    .i_csr_addr  (csr_addr),
    .i_csr_wdata (csr_wdata),
    .o_csr_rdata (csr_rdata),
    .i_out_wr    (out_wr),
    .i_out_data  (out_data),
    .o_out_full  (out_full),
    .i_in_rd     (in_rd),
    .o_in_data   (in_data),
    .o_in_last   (in_last),
    .o_in_empty  (in_empty),
    .o_tx_valid  (tx_valid),
    .o_tx_data   (tx_data),
    .o_tx_last   (tx_last),
    .i_tx_credit (tx_credit),
    .i_rx_valid  (rx_valid),
    .i_rx_data   (rx_data),
    .i_rx_last   (rx_last),
    .o_rx_credit (rx_credit),
    .o_pkt_sent  (pkt_sent),
    .o_pkt_recv  (pkt_recv)
  );

  initial begin
    clk_axi = 1'b0;
    forever #20 clk_axi = ~clk_axi;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      value_errors++;
      $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  task automatic csr_write(input csr_addr_e addr, input logic [31:0] data);
    @(negedge clk_axi);
    csr_wr    = 1'b1;
    csr_addr  = addr;
    csr_wdata = data;
    @(negedge clk_axi);
    csr_wr = 1'b0;
  endtask

  // Read data is registered, so it is taken one cycle after the strobe
  task automatic csr_read(input csr_addr_e addr, output logic [31:0] data);
    @(negedge clk_axi);
    csr_rd   = 1'b1;
    csr_addr = addr;
    @(negedge clk_axi);
    csr_rd = 1'b0;
    data   = csr_rdata;
  endtask

  task automatic clear_irqs();
    logic [31:0] status;
    csr_write(CTRL, 32'h2);
    csr_read(STATUS, status);
    check_value("STATUS", 32'h0, status);
    check_value("o_pkt_sent", 1'b0, pkt_sent);
    check_value("o_pkt_recv", 1'b0, pkt_recv);
  endtask

  task automatic expect_tx(input logic [7:0] data, input logic last);
    exp_tx.push_back(data);
    exp_tx_last.push_back(last);
  endtask

  task automatic send_packet();
    logic [15:0] src;
    logic [15:0] dst;
    logic [15:0] len;
    logic [63:0] hdr;
    logic [7:0]  payload [$];
    int          i;
    int          pushed;
    src = 16'($random(seed));
    dst = 16'($random(seed));
    len = 16'($unsigned($random(seed)) % (MAX_LEN + 1));
    for (i = 0; i < len; i++) payload.push_back(8'($random(seed)));
    // High byte first, length counts the header, zero checksum
    hdr = {src, dst, len + 16'd8, 16'h0000};
    for (i = 0; i < `UDP_HDR_BYTES; i++)
      expect_tx(hdr[63 - 8*i -: 8], (i == `UDP_HDR_BYTES - 1) && (len == 0));
    for (i = 0; i < len; i++) expect_tx(payload[i], i == len - 1);
    csr_write(SEND_PORTS, {dst, src});
    csr_write(SEND_LEN, {16'h0000, len});
    csr_write(CTRL, 32'h1);
    pushed = 0;
    while (pushed < len) begin
      @(negedge clk_axi);
      if (!out_full && ($random(seed) & 1)) begin
        out_wr   = 1'b1;
        out_data = payload[pushed];
        pushed++;
      end else begin
        out_wr = 1'b0;
      end
    end
    @(negedge clk_axi);
    out_wr = 1'b0;
    while (!pkt_sent) @(negedge clk_axi);
    assert (exp_tx.size() == 0) else begin
      flow_errors++;
      $display("Send ended at %0t ns with %0d expected bytes never sent", $time, exp_tx.size());
    end
    clear_irqs();
  endtask

  task automatic drive_frame();
    int idx;
    idx = 0;
    while (idx < rx_frame.size()) begin
      @(negedge clk_axi);
      if (rx_credits > 0 && ($random(seed) & 3) != 0) begin
        rx_valid = 1'b1;
        rx_data  = rx_frame[idx];
        rx_last  = (idx == rx_frame.size() - 1);
        rx_credits--;
        idx++;
      end else begin
        rx_valid = 1'b0;
        rx_last  = 1'b0;
      end
    end
    @(negedge clk_axi);
    rx_valid = 1'b0;
    rx_last  = 1'b0;
    rx_bytes_total += rx_frame.size();
  endtask

  task automatic drain_inbound();
    int popped;
    int tick;
    popped = 0;
    tick   = 0;
    while (popped < rx_payload.size()) begin
      @(negedge clk_axi);
      tick++;
      if (!in_empty && delay_tab[tick % 64] != 0) begin
        check_value("o_in_data", rx_payload[popped], in_data);
        check_value("o_in_last", popped == rx_payload.size() - 1, in_last);
        in_rd = 1'b1;
        popped++;
      end else begin
        in_rd = 1'b0;
      end
    end
    @(negedge clk_axi);
    in_rd = 1'b0;
  endtask

  task automatic recv_packet();
    logic [15:0] src;
    logic [15:0] dst;
    logic [15:0] len;
    logic [63:0] hdr;
    logic [31:0] rd;
    int          i;
    src = 16'($random(seed));
    dst = 16'($random(seed));
    len = 16'(1 + $unsigned($random(seed)) % MAX_LEN);
    hdr = {src, dst, len + 16'd8, 16'h0000};
    rx_frame.delete();
    rx_payload.delete();
    for (i = 0; i < `UDP_HDR_BYTES; i++) rx_frame.push_back(hdr[63 - 8*i -: 8]);
    for (i = 0; i < len; i++) begin
      rx_payload.push_back(8'($random(seed)));
      rx_frame.push_back(rx_payload[i]);
    end
    fork
      drive_frame();
      drain_inbound();
    join
    while (!pkt_recv) @(negedge clk_axi);
    csr_read(RECV_PORTS, rd);
    check_value("RECV_PORTS", {dst, src}, rd);
    csr_read(RECV_LEN, rd);
    check_value("RECV_LEN", {16'h0000, hdr[31:16]}, rd);
    clear_irqs();
  endtask

  // Output stream checker
  always @(posedge clk_axi) begin
    logic [7:0] exp_byte;
    logic       exp_last;
    if (sent_due) begin
      check_value("o_pkt_sent", 1'b1, pkt_sent);
      sent_due = 1'b0;
    end
    if (!rst_axi && tx_valid) begin
      beats_sent++;
      assert (beats_sent - credits_returned <= `UDP_TX_CREDITS) else begin
        flow_errors++;
        $display("Output stream went past its credits at %0t ns", $time);
      end
      assert (exp_tx.size() != 0) else begin
        flow_errors++;
        $display("Output beat at %0t ns with no byte left to send", $time);
      end
      if (exp_tx.size() != 0) begin
        exp_byte = exp_tx.pop_front();
        exp_last = exp_tx_last.pop_front();
        check_value("o_tx_data", exp_byte, tx_data);
        check_value("o_tx_last", exp_last, tx_last);
      end
      if (tx_last) begin
        check_value("o_pkt_sent", 1'b0, pkt_sent);
        sent_due = 1'b1;
      end
    end
  end

  // Host-side FIFO flags against a model of both fill levels
  always @(posedge clk_axi) begin
    if (!rst_axi) begin
      check_value("o_out_full", out_level == `UDP_FIFO_DEPTH, out_full);
      check_value("o_in_empty", in_level == 0, in_empty);
      if (out_wr) out_level++;
      if (tx_valid && tx_idx >= `UDP_HDR_BYTES) out_level--;
      if (tx_valid) tx_idx = tx_last ? 0 : tx_idx + 1;
      if (rx_valid && rx_idx >= `UDP_HDR_BYTES) in_level++;
      if (rx_valid) rx_idx = rx_last ? 0 : rx_idx + 1;
      if (in_rd) in_level--;
    end
  end

  // Receiver side of the output stream hands credits back after a delay
  always @(negedge clk_axi) begin
    if (rst_axi) begin
      tx_credit   = 1'b0;
      credit_wait = 0;
    end else if (beats_sent - credits_returned > 0 && credit_wait == 0) begin
      tx_credit = 1'b1;
      credits_returned++;
      credit_wait = delay_tab[credits_returned % 64];
    end else begin
      tx_credit = 1'b0;
      if (credit_wait > 0) credit_wait--;
    end
  end

  always @(posedge clk_axi) begin
    if (!rst_axi && rx_credit) begin
      rx_credit_pulses++;
      rx_credits++;
      assert (rx_credits <= `UDP_FIFO_DEPTH) else begin
        flow_errors++;
        $display("Input stream got back more credits than it spent at %0t ns", $time);
      end
    end
  end

  always @(posedge clk_axi) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the traffic never finished", cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    logic [31:0] rd;
    int          i;
    rst_axi   = 1'b1;
    csr_wr    = 1'b0;
    csr_rd    = 1'b0;
    csr_addr  = '0;
    csr_wdata = '0;
    out_wr    = 1'b0;
    out_data  = '0;
    in_rd     = 1'b0;
    rx_valid  = 1'b0;
    rx_data   = '0;
    rx_last   = 1'b0;
    for (i = 0; i < 64; i++) delay_tab[i] = $unsigned($random(seed)) % 4;
    repeat (4) @(posedge clk_axi);
    @(negedge clk_axi);
    rst_axi = 1'b0;

    check_value("o_tx_valid", 1'b0, tx_valid);
    check_value("o_rx_credit", 1'b0, rx_credit);
    check_value("o_pkt_sent", 1'b0, pkt_sent);
    check_value("o_pkt_recv", 1'b0, pkt_recv);
    csr_read(RECV_PORTS, rd);
    check_value("RECV_PORTS", 32'h0, rd);
    csr_read(RECV_LEN, rd);
    check_value("RECV_LEN", 32'h0, rd);
    csr_read(STATUS, rd);
    check_value("STATUS", 32'h0, rd);

    for (i = 0; i < N_PKTS; i++) send_packet();
    for (i = 0; i < N_PKTS; i++) recv_packet();

    // Owed credits still trickle out one per cycle
    i = 0;
    while (rx_credit_pulses != rx_bytes_total && i < 64) begin
      @(negedge clk_axi);
      i++;
    end
    check_value("o_rx_credit pulses", rx_bytes_total, rx_credit_pulses);

    $display("Errors: %0d value, %0d flow", value_errors, flow_errors);
    if (value_errors == 0 && flow_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== source/udp_bridge_top.sv ====
// Top level of the UDP bridge, connects the register block, both FIFOs, the framer and the parser
`timescale 1ns/1ns
`include "udp_params.svh"

module udp_bridge_top
  import udp_pkg::*;
(
  input  logic                   i_clk_axi,
  input  logic                   i_rst_axi,
  input  logic                   i_csr_wr,
  input  logic                   i_csr_rd,
  input  logic [`CSR_ADDR_W-1:0] i_csr_addr,
  input  logic [`CSR_DATA_W-1:0] i_csr_wdata,
  output logic [`CSR_DATA_W-1:0] o_csr_rdata,
  input  logic                   i_out_wr,
  input  logic [`UDP_DATA_W-1:0] i_out_data,
  output logic                   o_out_full,
  input  logic                   i_in_rd,
  output logic [`UDP_DATA_W-1:0] o_in_data,
  output logic                   o_in_last,
  output logic                   o_in_empty,
  output logic                   o_tx_valid,
  output logic [`UDP_DATA_W-1:0] o_tx_data,
  output logic                   o_tx_last,
  input  logic                   i_tx_credit,
  input  logic                   i_rx_valid,
  input  logic [`UDP_DATA_W-1:0] i_rx_data,
  input  logic                   i_rx_last,
  output logic                   o_rx_credit,
  output logic                   o_pkt_sent,
  output logic                   o_pkt_recv
);

  udp_hdr_if send_hdr_if ();
  udp_hdr_if recv_hdr_if ();

  logic                   out_pop;
  logic [`UDP_DATA_W-1:0] out_rdata;
  logic                   out_empty;
  logic [`UDP_CNT_W-1:0]  out_count;
  logic                   in_push;
  rx_beat_t               in_wbeat;
  rx_beat_t               in_rbeat;
  logic                   in_full;
  logic [`UDP_CNT_W-1:0]  in_count;
  logic                   tx_done;

  assign o_in_data = in_rbeat.data;
  assign o_in_last = in_rbeat.last;

  eth_csr u_eth_csr (
    .i_clk_axi   (i_clk_axi),
    .i_rst_axi   (i_rst_axi),
    .i_csr_wr    (i_csr_wr),
    .i_csr_rd    (i_csr_rd),
    .i_csr_addr  (i_csr_addr),
    .i_csr_wdata (i_csr_wdata),
    .o_csr_rdata (o_csr_rdata),
    .send_hdr    (send_hdr_if.src),
    .recv_hdr    (recv_hdr_if.dst),
    .i_tx_done   (tx_done),
    .i_in_count  (in_count),
    .i_out_count (out_count),
    .o_pkt_sent  (o_pkt_sent),
    .o_pkt_recv  (o_pkt_recv)
  );

  byte_fifo #(
    .entry_t (logic [`UDP_DATA_W-1:0]),
    .DEPTH   (`UDP_FIFO_DEPTH)
  ) u_outfifo (
    .i_clk_axi (i_clk_axi),
    .i_rst_axi (i_rst_axi),
    .i_push    (i_out_wr),
    .i_wdata   (i_out_data),
    .o_full    (o_out_full),
    .i_pop     (out_pop),
    .o_rdata   (out_rdata),
    .o_empty   (out_empty),
    .o_count   (out_count)
  );

  byte_fifo #(
    .entry_t (rx_beat_t),
    .DEPTH   (`UDP_FIFO_DEPTH)
  ) u_infifo (
    .i_clk_axi (i_clk_axi),
    .i_rst_axi (i_rst_axi),
    .i_push    (in_push),
    .i_wdata   (in_wbeat),
    .o_full    (in_full),
    .i_pop     (i_in_rd),
    .o_rdata   (in_rbeat),
    .o_empty   (o_in_empty),
    .o_count   (in_count)
  );

  udp_tx_framer u_udp_tx_framer (
    .i_clk_axi    (i_clk_axi),
    .i_rst_axi    (i_rst_axi),
    .send_hdr     (send_hdr_if.dst),
    .o_pop        (out_pop),
    .i_pop_data   (out_rdata),
    .i_fifo_empty (out_empty),
    .o_tx_valid   (o_tx_valid),
    .o_tx_data    (o_tx_data),
    .o_tx_last    (o_tx_last),
    .i_tx_credit  (i_tx_credit),
    .o_done       (tx_done)
  );

  udp_rx_parser u_udp_rx_parser (
    .i_clk_axi   (i_clk_axi),
    .i_rst_axi   (i_rst_axi),
    .i_rx_valid  (i_rx_valid),
    .i_rx_data   (i_rx_data),
    .i_rx_last   (i_rx_last),
    .o_push      (in_push),
    .o_push_beat (in_wbeat),
    .i_fifo_full (in_full),
    .i_host_pop  (i_in_rd),
    .o_rx_credit (o_rx_credit),
    .recv_hdr    (recv_hdr_if.src)
  );

endmodule

// ==== source/udp_rx_parser.sv ====
// Splits an incoming UDP datagram into its header and payload beats and returns stream credits
`timescale 1ns/1ns
`include "udp_params.svh"

module udp_rx_parser
  import udp_pkg::*;
(
  input  logic                   i_clk_axi,
  input  logic                   i_rst_axi,
  input  logic                   i_rx_valid,
  input  logic [`UDP_DATA_W-1:0] i_rx_data,
  input  logic                   i_rx_last,
  output logic                   o_push,
  output rx_beat_t               o_push_beat,
  input  logic                   i_fifo_full,
  input  logic                   i_host_pop,
  output logic                   o_rx_credit,
  udp_hdr_if.src                 recv_hdr
);

  localparam int HCNT_W = $clog2(`UDP_HDR_BYTES + 1);
  localparam int HDR_BITS = `UDP_HDR_BYTES * `UDP_DATA_W;
  localparam int OWE_W = $clog2(`UDP_FIFO_DEPTH + 1);
  localparam int SUM_W = OWE_W + 1;
  localparam logic [HCNT_W-1:0] HDR_DONE = HCNT_W'(`UDP_HDR_BYTES);

  logic [HCNT_W-1:0]   hdr_cnt;
  logic [HDR_BITS-1:0] hdr_shift;
  logic                in_hdr;
  logic                hdr_take;
  logic [OWE_W-1:0]    owed;
  logic [SUM_W-1:0]    credit_sum;

  assign in_hdr   = (hdr_cnt != HDR_DONE);
  assign hdr_take = i_rx_valid && in_hdr;

  assign o_push           = i_rx_valid && !in_hdr;
  assign o_push_beat.data = i_rx_data;
  assign o_push_beat.last = i_rx_last;

  // Checksum bytes sit in the low bits and are dropped
  assign recv_hdr.hdr_valid = o_push && i_rx_last;
  assign recv_hdr.hdr       = hdr_shift[HDR_BITS-1 -: $bits(udp_hdr_t)];

  always_ff @(posedge i_clk_axi) begin
    if (i_rst_axi) begin
      hdr_cnt <= '0;
    end else if (hdr_take) begin
      hdr_cnt <= hdr_cnt + 1'b1;
    end else if (recv_hdr.hdr_valid) begin
      hdr_cnt <= '0;
    end
  end

  always_ff @(posedge i_clk_axi) begin
    if (hdr_take) hdr_shift <= {hdr_shift[HDR_BITS-`UDP_DATA_W-1:0], i_rx_data};
  end

  // A header byte and a host pop in one cycle leave a credit owed for later
  assign credit_sum = SUM_W'(owed) + SUM_W'(hdr_take) + SUM_W'(i_host_pop);

  always_ff @(posedge i_clk_axi) begin
    if (i_rst_axi) begin
      o_rx_credit <= 1'b0;
      owed        <= '0;
    end else if (credit_sum != '0) begin
      o_rx_credit <= 1'b1;
      owed        <= OWE_W'(credit_sum - 1'b1);
    end else begin
      o_rx_credit <= 1'b0;
      owed        <= '0;
    end
  end

  a_no_short_hdr: assert property (@(posedge i_clk_axi) disable iff (i_rst_axi)
    hdr_take |-> !i_rx_last);
  a_sender_credits: assert property (@(posedge i_clk_axi) disable iff (i_rst_axi)
    !(o_push && i_fifo_full));

endmodule

// ==== source/udp_tx_framer.sv ====
// Sends the UDP header and then the outbound payload on the credit-controlled output stream
`timescale 1ns/1ns
`include "udp_params.svh"

module udp_tx_framer
  import udp_pkg::*;
(
  input  logic                   i_clk_axi,
  input  logic                   i_rst_axi,
  udp_hdr_if.dst                 send_hdr,
  output logic                   o_pop,
  input  logic [`UDP_DATA_W-1:0] i_pop_data,
  input  logic                   i_fifo_empty,
  output logic                   o_tx_valid,
  output logic [`UDP_DATA_W-1:0] o_tx_data,
  output logic                   o_tx_last,
  input  logic                   i_tx_credit,
  output logic                   o_done
);

  localparam int CRED_W = $clog2(`UDP_TX_CREDITS + 1);
  localparam int IDX_W = $clog2(`UDP_HDR_BYTES);
  localparam logic [IDX_W-1:0] HDR_TOP = IDX_W'(`UDP_HDR_BYTES - 1);

  typedef enum logic [1:0] {ST_IDLE, ST_HDR, ST_PAY} state_e;

  state_e                                         state;
  logic [15:0]                                    byte_cnt;
  logic [CRED_W-1:0]                              credits;
  udp_hdr_t                                       hdr_q;
  logic [`UDP_HDR_BYTES-1:0][`UDP_DATA_W-1:0]     hdr_bytes;
  logic [IDX_W-1:0]                               hdr_idx;
  logic                                           has_credit;

  assign send_hdr.hdr_ready = (state == ST_IDLE);
  assign has_credit = (credits != '0);
  assign hdr_idx = byte_cnt[IDX_W-1:0];
  // Length field covers header plus payload, checksum always zero
  assign hdr_bytes = {hdr_q.src_port, hdr_q.dst_port,
                      hdr_q.length + 16'(`UDP_HDR_BYTES), 16'h0000};

  always_comb begin
    o_tx_valid = 1'b0;
    o_tx_data  = '0;
    o_tx_last  = 1'b0;
    case (state)
      ST_HDR: begin
        o_tx_valid = has_credit;
        o_tx_data  = hdr_bytes[HDR_TOP - hdr_idx];
        o_tx_last  = (hdr_idx == HDR_TOP) && (hdr_q.length == 16'd0);
      end
      ST_PAY: begin
        o_tx_valid = has_credit && !i_fifo_empty;
        o_tx_data  = i_pop_data;
        o_tx_last  = (byte_cnt == hdr_q.length - 16'd1);
      end
      default: ;
    endcase
  end

  assign o_pop  = o_tx_valid && (state == ST_PAY);
  assign o_done = o_tx_valid && o_tx_last;

  always_ff @(posedge i_clk_axi) begin
    if (i_rst_axi) begin
      state    <= ST_IDLE;
      byte_cnt <= '0;
      credits  <= CRED_W'(`UDP_TX_CREDITS);
    end else begin
      credits <= credits - CRED_W'(o_tx_valid) + CRED_W'(i_tx_credit);
      case (state)
        ST_IDLE: begin
          if (send_hdr.hdr_valid) begin
            state    <= ST_HDR;
            byte_cnt <= '0;
          end
        end
        ST_HDR: begin
          if (o_tx_valid) begin
            if (o_tx_last) begin
              state <= ST_IDLE;
            end else if (hdr_idx == HDR_TOP) begin
              state    <= ST_PAY;
              byte_cnt <= '0;
            end else begin
              byte_cnt <= byte_cnt + 16'd1;
            end
          end
        end
        ST_PAY: begin
          if (o_tx_valid) begin
            if (o_tx_last) state <= ST_IDLE;
            byte_cnt <= byte_cnt + 16'd1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk_axi) begin
    if ((state == ST_IDLE) && send_hdr.hdr_valid) hdr_q <= send_hdr.hdr;
  end

  // Receiver returns no more credits than beats it was sent
  a_credit_bound: assert property (@(posedge i_clk_axi) disable iff (i_rst_axi)
    credits <= CRED_W'(`UDP_TX_CREDITS));

endmodule

// ==== source/byte_fifo.sv ====
// Show-ahead synchronous FIFO, used for both the outbound bytes and the inbound beats
`timescale 1ns/1ns
`include "udp_params.svh"

module byte_fifo #(
  parameter type entry_t = logic [`UDP_DATA_W-1:0],
  parameter int DEPTH = `UDP_FIFO_DEPTH,
  localparam int CNT_W = $clog2(DEPTH + 1)
) (
  input  logic             i_clk_axi,
  input  logic             i_rst_axi,
  input  logic             i_push,
  input  entry_t           i_wdata,
  output logic             o_full,
  input  logic             i_pop,
  output entry_t           o_rdata,
  output logic             o_empty,
  output logic [CNT_W-1:0] o_count
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(DEPTH - 1);

  entry_t           mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  assign o_full  = (count == CNT_W'(DEPTH));
  assign o_empty = (count == '0);
  assign o_count = count;
  // Head entry is visible before the pop
  assign o_rdata = mem[rd_ptr];

  always_ff @(posedge i_clk_axi) begin
    if (i_push) mem[wr_ptr] <= i_wdata;
  end

  always_ff @(posedge i_clk_axi) begin
    if (i_rst_axi) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
      if (i_pop) rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
      case ({i_push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge i_clk_axi) disable iff (i_rst_axi)
    !(i_push && o_full));
  a_no_underflow: assert property (@(posedge i_clk_axi) disable iff (i_rst_axi)
    !(i_pop && o_empty));

endmodule

// ==== source/eth_csr.sv ====
// Register block of the bridge, decodes host reads and writes and raises the interrupts
`timescale 1ns/1ns
`include "udp_params.svh"

module eth_csr
  import udp_pkg::*;
(
  input  logic                   i_clk_axi,
  input  logic                   i_rst_axi,
  input  logic                   i_csr_wr,
  input  logic                   i_csr_rd,
  input  logic [`CSR_ADDR_W-1:0] i_csr_addr,
  input  logic [`CSR_DATA_W-1:0] i_csr_wdata,
  output logic [`CSR_DATA_W-1:0] o_csr_rdata,
  udp_hdr_if.src                 send_hdr,
  udp_hdr_if.dst                 recv_hdr,
  input  logic                   i_tx_done,
  input  logic [`UDP_CNT_W-1:0]  i_in_count,
  input  logic [`UDP_CNT_W-1:0]  i_out_count,
  output logic                   o_pkt_sent,
  output logic                   o_pkt_recv
);

  csr_addr_e              addr;
  logic [15:0]            send_src;
  logic [15:0]            send_dst;
  logic [15:0]            send_len;
  udp_hdr_t               recv_q;
  logic                   send_pending;
  logic                   irq_sent;
  logic                   irq_recv;
  logic                   send_req;
  logic                   clear_irq;
  logic [`CSR_DATA_W-1:0] rd_mux;

  assign addr      = csr_addr_e'(i_csr_addr);
  assign send_req  = i_csr_wr && (addr == CTRL) && i_csr_wdata[0];
  assign clear_irq = i_csr_wr && (addr == CTRL) && i_csr_wdata[1];

  assign send_hdr.hdr_valid = send_pending;
  assign send_hdr.hdr       = {send_src, send_dst, send_len};
  assign recv_hdr.hdr_ready = 1'b1;

  assign o_pkt_sent = irq_sent;
  assign o_pkt_recv = irq_recv;

  always_ff @(posedge i_clk_axi) begin
    if (i_rst_axi) begin
      send_src <= '0;
      send_dst <= '0;
      send_len <= '0;
    end else if (i_csr_wr) begin
      case (addr)
        SEND_PORTS: begin
          send_src <= i_csr_wdata[15:0];
          send_dst <= i_csr_wdata[31:16];
        end
        SEND_LEN: send_len <= i_csr_wdata[15:0];
        default: ;
      endcase
    end
  end

  // Pending send stays up until the framer takes the header
  always_ff @(posedge i_clk_axi) begin
    if (i_rst_axi) begin
      send_pending <= 1'b0;
      irq_sent     <= 1'b0;
      irq_recv     <= 1'b0;
      recv_q       <= '0;
    end else begin
      if (send_hdr.hdr_ready) send_pending <= 1'b0;
      if (send_req) send_pending <= 1'b1;
      if (clear_irq) begin
        irq_sent <= 1'b0;
        irq_recv <= 1'b0;
      end
      if (i_tx_done) irq_sent <= 1'b1;
      if (recv_hdr.hdr_valid) begin
        irq_recv <= 1'b1;
        recv_q   <= recv_hdr.hdr;
      end
    end
  end

  always_comb begin
    case (addr)
      SEND_PORTS: rd_mux = {send_dst, send_src};
      SEND_LEN:   rd_mux = {16'h0000, send_len};
      RECV_PORTS: rd_mux = {recv_q.dst_port, recv_q.src_port};
      RECV_LEN:   rd_mux = {16'h0000, recv_q.length};
      STATUS:     rd_mux = {8'h00, 8'(i_out_count), 8'(i_in_count), 6'b0, irq_sent, irq_recv};
      default:    rd_mux = '0;
    endcase
  end

  always_ff @(posedge i_clk_axi) begin
    if (i_rst_axi) begin
      o_csr_rdata <= '0;
    end else if (i_csr_rd) begin
      o_csr_rdata <= rd_mux;
    end
  end

  // Host waits for the previous send to be taken before requesting another
  a_no_send_overlap: assert property (@(posedge i_clk_axi) disable iff (i_rst_axi)
    !(send_req && send_pending));

endmodule

// ==== source/udp_hdr_if.sv ====
// UDP header bundle with valid/ready, instantiated once per direction inside the bridge
`timescale 1ns/1ns

interface udp_hdr_if
  import udp_pkg::*;
();

  logic     hdr_valid;
  logic     hdr_ready;
  udp_hdr_t hdr;

  modport src (
    output hdr_valid,
    output hdr,
    input  hdr_ready
  );

  modport dst (
    input  hdr_valid,
    input  hdr,
    output hdr_ready
  );

endinterface

// ==== source/udp_pkg.sv ====
// Shared types of the UDP bridge, imported by the modules that pass headers or inbound beats
`include "udp_params.svh"

package udp_pkg;

  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;
  } udp_hdr_t;

  // Inbound FIFO entry keeps the frame boundary for the host
  typedef struct packed {
    logic [`UDP_DATA_W-1:0] data;
    logic                   last;
  } rx_beat_t;

  typedef enum logic [`CSR_ADDR_W-1:0] {
    CTRL       = 3'd0,
    SEND_PORTS = 3'd1,
    SEND_LEN   = 3'd2,
    RECV_PORTS = 3'd3,
    RECV_LEN   = 3'd4,
    STATUS     = 3'd5
  } csr_addr_e;

endpackage

// ==== source/udp_params.svh ====
// Widths, depths and counts shared by the UDP bridge, included by every file that sizes a port
`ifndef UDP_PARAMS_SVH
`define UDP_PARAMS_SVH

// Stream byte and header
`define UDP_DATA_W 8
`define UDP_HDR_BYTES 8

// Buffering and flow control
`define UDP_FIFO_DEPTH 16
`define UDP_TX_CREDITS 4

// FIFO fill level, wide enough to hold a full FIFO
`define UDP_CNT_W ($clog2(`UDP_FIFO_DEPTH + 1))

// Register bus
`define CSR_ADDR_W 3
`define CSR_DATA_W 32

`endif
